// File: eth_udp_pkg.sv
/*
  Shared definitions for the UDP endpoint.
  Holds the UDP header union, the APB register map and the payload FIFO
  sizing. Modules pull it in with a wildcard import in their header.
*/
package eth_udp_pkg;

  // Header on the wire and payload buffering
  localparam int UDP_HDR_BYTES = 8;
  localparam int FIFO_DEPTH    = 256;
  localparam int FIFO_AW       = 8;
  localparam int SEND_LEN_W    = 9;

  // APB register map in byte offsets
  localparam int APB_AW = 8;

  localparam logic [APB_AW-1:0] REG_SEND_PORTS = 8'h00;
  localparam logic [APB_AW-1:0] REG_SEND_LEN   = 8'h04;
  localparam logic [APB_AW-1:0] REG_TX_DATA    = 8'h08;
  localparam logic [APB_AW-1:0] REG_CTRL       = 8'h0C;
  localparam logic [APB_AW-1:0] REG_STATUS     = 8'h10;
  localparam logic [APB_AW-1:0] REG_RECV_PORTS = 8'h14;
  localparam logic [APB_AW-1:0] REG_RECV_LEN   = 8'h18;
  localparam logic [APB_AW-1:0] REG_RX_DATA    = 8'h1C;

  // CTRL write bits
  localparam int CTRL_SEND     = 0;
  localparam int CTRL_CLR_IRQ  = 1;
  localparam int CTRL_CLR_RXF  = 2;
  localparam int CTRL_CLR_TXF  = 3;

  // UDP header read as fields by the registers and as bytes on the wire
  // b[7] is the first byte sent
  typedef union packed {
    struct packed {
      logic [15:0] src_port;
      logic [15:0] dst_port;
      logic [15:0] length;
      logic [15:0] checksum;
    } f;
    logic [UDP_HDR_BYTES-1:0][7:0] b;
  } udp_hdr_u;

endpackage

// File: pkt_fifo.sv
/*
  Circular byte buffer for UDP payloads.
  Used once for transmit and once for receive. Clear empties it in one
  cycle; a push when full or a pop when empty is dropped.
*/
module pkt_fifo
  import eth_udp_pkg::*;
(
  input  logic               i_clk_125MHz,
  input  logic               i_rst_int,
  input  logic               i_push,
  input  logic [7:0]         i_push_data,
  input  logic               i_pop,
  input  logic               i_clear,
  output logic [7:0]         o_head,
  output logic               o_empty,
  output logic               o_full,
  output logic [FIFO_AW:0]   o_count
);
  logic [7:0]         mem [FIFO_DEPTH];
  logic [FIFO_AW-1:0] wr_ptr;
  logic [FIFO_AW-1:0] rd_ptr;
  logic [FIFO_AW:0]   next_count;
  logic               do_push;
  logic               do_pop;

  assign do_push = i_push && !o_full;
  assign do_pop  = i_pop && !o_empty;
  assign o_head  = mem[rd_ptr];

  always_comb begin
    next_count = o_count;
    if (do_push && !do_pop) begin
      next_count = o_count + 1'b1;
    end else if (do_pop && !do_push) begin
      next_count = o_count - 1'b1;
    end
  end

  always_ff @(posedge i_clk_125MHz) begin
    if (i_rst_int || i_clear) begin
      wr_ptr  <= '0;
      rd_ptr  <= '0;
      o_count <= '0;
      o_empty <= 1'b1;
      o_full  <= 1'b0;
    end else begin
      if (do_push) begin
        wr_ptr <= wr_ptr + 1'b1;
      end
      if (do_pop) begin
        rd_ptr <= rd_ptr + 1'b1;
      end
      o_count <= next_count;
      // Flags are registered alongside the count
      o_empty <= (next_count == '0);
      o_full  <= (next_count == (FIFO_AW+1)'(FIFO_DEPTH));
    end
  end

  always_ff @(posedge i_clk_125MHz) begin
    if (do_push) begin
      mem[wr_ptr] <= i_push_data;
    end
  end

  a_count_max: assert property (@(posedge i_clk_125MHz) disable iff (i_rst_int)
    o_count <= (FIFO_AW+1)'(FIFO_DEPTH));

  // Pointers meet with the buffer not full only when nothing is stored
  a_empty_flag: assert property (@(posedge i_clk_125MHz) disable iff (i_rst_int)
    o_empty == ((wr_ptr == rd_ptr) && !o_full));

endmodule

// File: udp_tx_framer.sv
/*
  UDP transmit framer.
  On a send request it captures ports and length, then streams the
  8 header bytes followed by the payload taken from the transmit FIFO.
  Checksum goes out as zero. An empty FIFO stalls valid.
*/
module udp_tx_framer
  import eth_udp_pkg::*;
(
  input  logic                  i_clk_125MHz,
  input  logic                  i_rst_int,
  input  logic                  i_send_req,
  input  logic [15:0]           i_src_port,
  input  logic [15:0]           i_dst_port,
  input  logic [SEND_LEN_W-1:0] i_len,
  input  logic [7:0]            i_fifo_head,
  input  logic                  i_fifo_empty,
  input  logic                  i_tx_ready,
  output logic                  o_fifo_pop,
  output logic [7:0]            o_tx_data,
  output logic                  o_tx_valid,
  output logic                  o_tx_last,
  output logic                  o_busy,
  output logic                  o_done
);
  udp_hdr_u              hdr;
  logic [SEND_LEN_W:0]   cnt;
  logic [SEND_LEN_W:0]   last_idx;
  logic                  start;
  logic                  in_hdr;
  logic                  hs;

  assign start  = i_send_req && !o_busy;
  assign in_hdr = (cnt < UDP_HDR_BYTES);
  assign hs     = o_tx_valid && i_tx_ready;

  // Header bytes go first with the most significant byte of each field leading
  assign o_tx_data  = in_hdr ? hdr.b[3'(UDP_HDR_BYTES - 1) - cnt[2:0]] : i_fifo_head;
  assign o_tx_valid = o_busy && (in_hdr || !i_fifo_empty);
  assign o_tx_last  = (cnt == last_idx);
  assign o_fifo_pop = hs && !in_hdr;

  always_ff @(posedge i_clk_125MHz) begin
    if (i_rst_int) begin
      o_busy <= 1'b0;
      o_done <= 1'b0;
      cnt    <= '0;
    end else begin
      o_done <= hs && o_tx_last;
      if (start) begin
        o_busy <= 1'b1;
        cnt    <= '0;
      end else if (hs) begin
        if (o_tx_last) begin
          o_busy <= 1'b0;
        end
        cnt <= cnt + 1'b1;
      end
    end
  end

  always_ff @(posedge i_clk_125MHz) begin
    if (start) begin
      hdr.f.src_port <= i_src_port;
      hdr.f.dst_port <= i_dst_port;
      hdr.f.length   <= 16'(i_len) + 16'(UDP_HDR_BYTES);
      hdr.f.checksum <= '0;
      last_idx       <= {1'b0, i_len} + (SEND_LEN_W+1)'(UDP_HDR_BYTES - 1);
    end
  end

  a_stall_stable: assert property (@(posedge i_clk_125MHz) disable iff (i_rst_int)
    o_tx_valid && !i_tx_ready |=> o_tx_valid && $stable(o_tx_data) && $stable(o_tx_last));

endmodule

// File: udp_rx_parser.sv
/*
  UDP receive parser.
  The first 8 bytes of a frame build the header, later bytes go to the
  receive FIFO. At the last byte a frame of at least 8 bytes latches the
  header and pulses done; shorter frames are dropped.
*/
module udp_rx_parser
  import eth_udp_pkg::*;
(
  input  logic       i_clk_125MHz,
  input  logic       i_rst_int,
  input  logic [7:0] i_rx_data,
  input  logic       i_rx_valid,
  input  logic       i_rx_last,
  input  logic       i_fifo_full,
  output logic       o_rx_ready,
  output logic       o_fifo_push,
  output logic [7:0] o_fifo_data,
  output udp_hdr_u   o_recv_hdr,
  output logic       o_done
);
  udp_hdr_u   work;
  udp_hdr_u   next_work;
  logic [3:0] cnt;
  logic       in_hdr;
  logic       hs;
  logic       hdr_complete;

  assign in_hdr      = (cnt < UDP_HDR_BYTES);
  // Stall only for a payload byte with nowhere to go
  assign o_rx_ready  = in_hdr || !i_fifo_full;
  assign hs          = i_rx_valid && o_rx_ready;
  assign o_fifo_push = hs && !in_hdr;
  assign o_fifo_data = i_rx_data;

  // Includes a frame whose last byte is the 8th header byte
  assign hdr_complete = !in_hdr || (cnt == 4'(UDP_HDR_BYTES - 1));

  always_comb begin
    next_work = work;
    if (in_hdr) begin
      next_work.b = {work.b[UDP_HDR_BYTES-2:0], i_rx_data};
    end
  end

  always_ff @(posedge i_clk_125MHz) begin
    if (i_rst_int) begin
      cnt        <= '0;
      o_done     <= 1'b0;
      o_recv_hdr <= '0;
    end else begin
      o_done <= 1'b0;
      if (hs) begin
        if (i_rx_last) begin
          cnt <= '0;
          if (hdr_complete) begin
            o_recv_hdr <= next_work;
            o_done     <= 1'b1;
          end
        end else if (in_hdr) begin
          cnt <= cnt + 1'b1;
        end
      end
    end
  end

  always_ff @(posedge i_clk_125MHz) begin
    if (hs) begin
      work <= next_work;
    end
  end

endmodule

// File: eth_csr_apb.sv
/*
  APB register block of the UDP endpoint.
  Zero wait states. Holds send ports and length, feeds both payload FIFOs,
  keeps a pending send until the framer is idle and owns the two
  interrupt flags. Unmapped accesses and writes to read-only registers
  return PSLVERR and change nothing.
*/
module eth_csr_apb
  import eth_udp_pkg::*;
(
  input  logic                  i_clk_125MHz,
  input  logic                  i_rst_int,
  input  logic                  i_psel,
  input  logic                  i_penable,
  input  logic                  i_pwrite,
  input  logic [APB_AW-1:0]     i_paddr,
  input  logic [31:0]           i_pwdata,
  output logic [31:0]           o_prdata,
  output logic                  o_pready,
  output logic                  o_pslverr,
  input  logic [7:0]            i_rx_head,
  input  logic                  i_rx_empty,
  input  logic [FIFO_AW:0]      i_rx_count,
  input  logic                  i_tx_empty,
  input  logic                  i_tx_full,
  input  logic                  i_tx_busy,
  input  logic                  i_tx_done,
  input  logic                  i_rx_done,
  input  udp_hdr_u              i_recv_hdr,
  output logic                  o_tx_push,
  output logic [7:0]            o_tx_push_data,
  output logic                  o_rx_pop,
  output logic                  o_rx_clear,
  output logic                  o_tx_clear,
  output logic                  o_send_req,
  output logic [15:0]           o_src_port,
  output logic [15:0]           o_dst_port,
  output logic [SEND_LEN_W-1:0] o_len,
  output logic                  o_pkt_recv,
  output logic                  o_pkt_sent
);
  logic access;
  logic mapped;
  logic read_only;
  logic wr_ok;
  logic ctrl_wr;
  logic clr_irq;
  logic send_pend;

  assign access    = i_psel && i_penable;
  assign o_pready  = 1'b1;
  assign o_pslverr = access && (!mapped || (i_pwrite && read_only));
  assign wr_ok     = access && i_pwrite && !o_pslverr;

  always_comb begin
    mapped    = 1'b1;
    read_only = 1'b0;
    o_prdata  = '0;
    case (i_paddr)
      REG_SEND_PORTS: o_prdata = {o_src_port, o_dst_port};
      REG_SEND_LEN:   o_prdata = 32'(o_len);
      REG_TX_DATA, REG_CTRL: o_prdata = '0;
      REG_STATUS: begin
        read_only = 1'b1;
        o_prdata  = {7'b0, i_rx_count, 11'b0, i_tx_full, i_tx_empty, i_rx_empty,
                     o_pkt_sent, o_pkt_recv};
      end
      REG_RECV_PORTS: begin
        read_only = 1'b1;
        o_prdata  = {i_recv_hdr.f.src_port, i_recv_hdr.f.dst_port};
      end
      REG_RECV_LEN: begin
        read_only = 1'b1;
        o_prdata  = 32'(i_recv_hdr.f.length);
      end
      REG_RX_DATA: begin
        read_only = 1'b1;
        o_prdata  = i_rx_empty ? '0 : 32'(i_rx_head);
      end
      default: mapped = 1'b0;
    endcase
  end

  // FIFO and command strobes
  assign ctrl_wr        = wr_ok && (i_paddr == REG_CTRL);
  assign clr_irq        = ctrl_wr && i_pwdata[CTRL_CLR_IRQ];
  assign o_rx_clear     = ctrl_wr && i_pwdata[CTRL_CLR_RXF];
  assign o_tx_clear     = ctrl_wr && i_pwdata[CTRL_CLR_TXF];
  assign o_tx_push      = wr_ok && (i_paddr == REG_TX_DATA);
  assign o_tx_push_data = i_pwdata[7:0];
  assign o_rx_pop       = access && !i_pwrite && (i_paddr == REG_RX_DATA) && !i_rx_empty;
  assign o_send_req     = send_pend && !i_tx_busy;

  always_ff @(posedge i_clk_125MHz) begin
    if (i_rst_int) begin
      o_src_port <= '0;
      o_dst_port <= '0;
      o_len      <= '0;
      send_pend  <= 1'b0;
      o_pkt_recv <= 1'b0;
      o_pkt_sent <= 1'b0;
    end else begin
      if (wr_ok && (i_paddr == REG_SEND_PORTS)) begin
        o_src_port <= i_pwdata[31:16];
        o_dst_port <= i_pwdata[15:0];
      end
      if (wr_ok && (i_paddr == REG_SEND_LEN)) begin
        o_len <= i_pwdata[SEND_LEN_W-1:0];
      end
      if (ctrl_wr && i_pwdata[CTRL_SEND]) begin
        send_pend <= 1'b1;
      end else if (o_send_req) begin
        send_pend <= 1'b0;
      end
      // Clear beats a done pulse in the same cycle
      o_pkt_recv <= !clr_irq && (o_pkt_recv || i_rx_done);
      o_pkt_sent <= !clr_irq && (o_pkt_sent || i_tx_done);
    end
  end

endmodule

// File: udp_endpoint.sv
/*
  Top of the single-clock UDP endpoint.
  APB register block, transmit and receive payload FIFOs, header framer
  and header parser, joined by wires only.
*/
module udp_endpoint
  import eth_udp_pkg::*;
(
  input  logic              i_clk_125MHz,
  input  logic              i_rst_int,
  input  logic              i_psel,
  input  logic              i_penable,
  input  logic              i_pwrite,
  input  logic [APB_AW-1:0] i_paddr,
  input  logic [31:0]       i_pwdata,
  output logic [31:0]       o_prdata,
  output logic              o_pready,
  output logic              o_pslverr,
  output logic [7:0]        o_tx_data,
  output logic              o_tx_valid,
  output logic              o_tx_last,
  input  logic              i_tx_ready,
  input  logic [7:0]        i_rx_data,
  input  logic              i_rx_valid,
  input  logic              i_rx_last,
  output logic              o_rx_ready,
  output logic              o_pkt_recv,
  output logic              o_pkt_sent
);
  logic [7:0]            tx_push_data, tx_head, rx_head, rx_push_data;
  logic                  tx_push, tx_pop, tx_clear, tx_empty, tx_full;
  logic                  rx_push, rx_pop, rx_clear, rx_empty, rx_full;
  logic [FIFO_AW:0]      rx_count;
  logic                  send_req, tx_busy, tx_done, rx_done;
  logic [15:0]           src_port, dst_port;
  logic [SEND_LEN_W-1:0] send_len;
  udp_hdr_u              recv_hdr;

  eth_csr_apb u_csr (
    .i_clk_125MHz(i_clk_125MHz), .i_rst_int(i_rst_int),
    .i_psel(i_psel), .i_penable(i_penable), .i_pwrite(i_pwrite),
    .i_paddr(i_paddr), .i_pwdata(i_pwdata),
    .o_prdata(o_prdata), .o_pready(o_pready), .o_pslverr(o_pslverr),
    .i_rx_head(rx_head), .i_rx_empty(rx_empty), .i_rx_count(rx_count),
    .i_tx_empty(tx_empty), .i_tx_full(tx_full), .i_tx_busy(tx_busy),
    .i_tx_done(tx_done), .i_rx_done(rx_done), .i_recv_hdr(recv_hdr),
    .o_tx_push(tx_push), .o_tx_push_data(tx_push_data), .o_rx_pop(rx_pop),
    .o_rx_clear(rx_clear), .o_tx_clear(tx_clear), .o_send_req(send_req),
    .o_src_port(src_port), .o_dst_port(dst_port), .o_len(send_len),
    .o_pkt_recv(o_pkt_recv), .o_pkt_sent(o_pkt_sent)
  );

  // Transmit count is not exported
  pkt_fifo u_tx_fifo (
    .i_clk_125MHz(i_clk_125MHz), .i_rst_int(i_rst_int),
    .i_push(tx_push), .i_push_data(tx_push_data), .i_pop(tx_pop), .i_clear(tx_clear),
    .o_head(tx_head), .o_empty(tx_empty), .o_full(tx_full), .o_count()
  );

  pkt_fifo u_rx_fifo (
    .i_clk_125MHz(i_clk_125MHz), .i_rst_int(i_rst_int),
    .i_push(rx_push), .i_push_data(rx_push_data), .i_pop(rx_pop), .i_clear(rx_clear),
    .o_head(rx_head), .o_empty(rx_empty), .o_full(rx_full), .o_count(rx_count)
  );

  udp_tx_framer u_framer (
    .i_clk_125MHz(i_clk_125MHz), .i_rst_int(i_rst_int), .i_send_req(send_req),
    .i_src_port(src_port), .i_dst_port(dst_port), .i_len(send_len),
    .i_fifo_head(tx_head), .i_fifo_empty(tx_empty), .i_tx_ready(i_tx_ready),
    .o_fifo_pop(tx_pop), .o_tx_data(o_tx_data), .o_tx_valid(o_tx_valid),
    .o_tx_last(o_tx_last), .o_busy(tx_busy), .o_done(tx_done)
  );

  udp_rx_parser u_parser (
    .i_clk_125MHz(i_clk_125MHz), .i_rst_int(i_rst_int),
    .i_rx_data(i_rx_data), .i_rx_valid(i_rx_valid), .i_rx_last(i_rx_last),
    .i_fifo_full(rx_full), .o_rx_ready(o_rx_ready), .o_fifo_push(rx_push),
    .o_fifo_data(rx_push_data), .o_recv_hdr(recv_hdr), .o_done(rx_done)
  );

endmodule

// File: tb_udp_endpoint.sv
/*
  Self-checking testbench for the UDP endpoint.
  Drives APB accesses and a receive byte stream on the falling clock edge
  and lets concurrent assertions judge the register reads, slave errors,
  interrupt flags and every transmit byte against values built here.
*/
module tb_udp_endpoint
  import eth_udp_pkg::*;
();
  timeunit 1ns;
  timeprecision 100ps;

  localparam int SEND_BYTES = 20;
  localparam int RX_PAY     = 12;
  localparam int SHORT_LEN  = 5;
  localparam int CLR_BYTES  = 4;
  localparam int WATCHDOG_CYCLES =
    200 * ((SEND_BYTES + 8) + (RX_PAY + 8) + SHORT_LEN + CLR_BYTES) + 2000;

  logic clk_125MHz = 1'b0;
  logic rst_int;
  logic psel, penable, pwrite, pready, pslverr;
  logic [APB_AW-1:0] paddr;
  logic [31:0] pwdata, prdata;
  logic [7:0] tx_data, rx_data;
  logic tx_valid, tx_last, tx_ready, rx_valid, rx_last, rx_ready, pkt_recv, pkt_sent;

  // Check strobes and expected values for the assertions
  logic rd_chk = 1'b0, err_chk = 1'b0, flag_chk = 1'b0, idle_chk = 1'b0;
  logic err_exp;
  logic [1:0] flag_exp;
  logic [31:0] rd_exp, rd_mask;
  logic [7:0] exp_tx [64];
  logic [7:0] exp_byte;
  logic [7:0] lfsr = 8'd90;
  int exp_len = 0, tx_idx = 0;
  int errors = 0, err_mark = 0, n_tests = 0, n_bad = 0;

  always #4 clk_125MHz = ~clk_125MHz;

  udp_endpoint udp_endpoint_inst (
    .i_clk_125MHz(clk_125MHz), .i_rst_int(rst_int),
    .i_psel(psel), .i_penable(penable), .i_pwrite(pwrite),
    .i_paddr(paddr), .i_pwdata(pwdata),
    .o_prdata(prdata), .o_pready(pready), .o_pslverr(pslverr),
    .o_tx_data(tx_data), .o_tx_valid(tx_valid), .o_tx_last(tx_last), .i_tx_ready(tx_ready),
    .i_rx_data(rx_data), .i_rx_valid(rx_valid), .i_rx_last(rx_last), .o_rx_ready(rx_ready),
    .o_pkt_recv(pkt_recv), .o_pkt_sent(pkt_sent)
  );

  assign exp_byte = exp_tx[tx_idx[5:0]];

  always @(posedge clk_125MHz) begin
    if (tx_valid && tx_ready) begin
      tx_idx <= tx_idx + 1;
    end
  end

  a_prdata: assert property (@(posedge clk_125MHz) disable iff (rst_int)
    rd_chk && pready |-> (prdata & rd_mask) == rd_exp)
    else begin
      errors++;
      $display("CHECK FAILED o_prdata at %h: expected %h, got %h", $sampled(paddr),
               $sampled(rd_exp), $sampled(prdata) & $sampled(rd_mask));
    end

  a_pslverr: assert property (@(posedge clk_125MHz) disable iff (rst_int)
    err_chk && pready |-> pslverr == err_exp)
    else begin
      errors++;
      $display("CHECK FAILED o_pslverr at %h: expected %h, got %h", $sampled(paddr),
               $sampled(err_exp), $sampled(pslverr));
    end

  a_flags: assert property (@(posedge clk_125MHz) disable iff (rst_int)
    flag_chk |-> {pkt_recv, pkt_sent} == flag_exp)
    else begin
      errors++;
      $display("CHECK FAILED {o_pkt_recv,o_pkt_sent}: expected %h, got %h",
               $sampled(flag_exp), {$sampled(pkt_recv), $sampled(pkt_sent)});
    end

  a_idle: assert property (@(posedge clk_125MHz) disable iff (rst_int)
    idle_chk |-> {tx_valid, pkt_recv, pkt_sent, rx_ready} == 4'b0001)
    else begin
      errors++;
      $display("CHECK FAILED {o_tx_valid,o_pkt_recv,o_pkt_sent,o_rx_ready}: expected 1, got %h",
               {$sampled(tx_valid), $sampled(pkt_recv), $sampled(pkt_sent), $sampled(rx_ready)});
    end

  a_tx_extra: assert property (@(posedge clk_125MHz) disable iff (rst_int)
    tx_valid && tx_ready |-> tx_idx < exp_len)
    else begin
      errors++;
      $display("Transmit stream sent a byte beyond the expected frame");
    end

  a_tx_data: assert property (@(posedge clk_125MHz) disable iff (rst_int)
    tx_valid && tx_ready && tx_idx < exp_len |-> tx_data == exp_byte)
    else begin
      errors++;
      $display("CHECK FAILED o_tx_data byte %0d: expected %h, got %h", $sampled(tx_idx),
               $sampled(exp_byte), $sampled(tx_data));
    end

  a_tx_last: assert property (@(posedge clk_125MHz) disable iff (rst_int)
    tx_valid && tx_ready |-> tx_last == (tx_idx == exp_len - 1))
    else begin
      errors++;
      $display("CHECK FAILED o_tx_last byte %0d: expected %h, got %h", $sampled(tx_idx),
               $sampled(tx_idx) == exp_len - 1, $sampled(tx_last));
    end

  // Sent flag may only rise once the whole frame went out
  a_tx_count: assert property (@(posedge clk_125MHz) disable iff (rst_int)
    $rose(pkt_sent) |-> tx_idx == exp_len)
    else begin
      errors++;
      $display("CHECK FAILED transmit byte count: expected %h, got %h", exp_len, tx_idx);
    end

  function automatic logic [7:0] lfsr_next(input logic [7:0] s);
    return {s[6:0], s[7] ^ s[5] ^ s[4] ^ s[3]};
  endfunction

  task automatic rand_bits(input int n, output logic [7:0] v);
    v = '0;
    for (int i = 0; i < n; i++) begin
      v = {v[6:0], lfsr[7]};
      lfsr = lfsr_next(lfsr);
    end
  endtask

  task automatic apb_xfer(input logic wr, input logic [APB_AW-1:0] addr, input logic [31:0] val,
                          input logic [31:0] mask, input logic exp_err);
    int waits;
    waits = 0;
    @(negedge clk_125MHz);
    psel = 1'b1;
    pwrite = wr;
    paddr = addr;
    pwdata = wr ? val : 32'h0;
    @(negedge clk_125MHz);
    penable = 1'b1;
    rd_chk = !wr;
    rd_exp = val & mask;
    rd_mask = mask;
    err_chk = 1'b1;
    err_exp = exp_err;
    while (!pready && waits < 16) begin
      @(negedge clk_125MHz);
      waits++;
    end
    @(negedge clk_125MHz);
    if (waits == 16) begin
      errors++;
      $display("APB transfer at %h never completed", addr);
    end
    psel = 1'b0;
    penable = 1'b0;
    rd_chk = 1'b0;
    err_chk = 1'b0;
  endtask

  task automatic apb_write(input logic [APB_AW-1:0] addr, input logic [31:0] data,
                           input logic exp_err);
    apb_xfer(1'b1, addr, data, 32'h0, exp_err);
  endtask

  task automatic apb_read(input logic [APB_AW-1:0] addr, input logic [31:0] exp,
                          input logic [31:0] mask, input logic exp_err);
    apb_xfer(1'b0, addr, exp, mask, exp_err);
  endtask

  task automatic drive_rx_byte(input logic [7:0] data, input logic last);
    int waits;
    waits = 0;
    rx_data = data;
    rx_valid = 1'b1;
    rx_last = last;
    while (!rx_ready && waits < 1000) begin
      @(negedge clk_125MHz);
      waits++;
    end
    @(negedge clk_125MHz);
    if (waits == 1000) begin
      errors++;
      $display("Receive stream stayed stalled with a byte waiting");
    end
    rx_valid = 1'b0;
    rx_last = 1'b0;
  endtask

  task automatic check_flags(input logic [1:0] exp);
    flag_exp = exp;
    flag_chk = 1'b1;
    @(negedge clk_125MHz);
    flag_chk = 1'b0;
  endtask

  task automatic finish_test(input string name);
    n_tests++;
    if (errors == err_mark) begin
      $display("test %0d %s: ok", n_tests, name);
    end else begin
      n_bad++;
      $display("test %0d %s: %0d failures", n_tests, name, errors - err_mark);
    end
    err_mark = errors;
  endtask

  initial begin
    repeat (WATCHDOG_CYCLES) @(posedge clk_125MHz);
    $display("Watchdog expired before the tests finished");
    $display("Some tests failed");
    $finish;
  end

  initial begin
    logic [7:0] b;
    logic [63:0] hdr;
    logic [7:0] rx_exp [RX_PAY];
    int waits;
    rst_int = 1'b1;
    psel = 1'b0;
    penable = 1'b0;
    pwrite = 1'b0;
    paddr = '0;
    pwdata = '0;
    tx_ready = 1'b0;
    rx_data = '0;
    rx_valid = 1'b0;
    rx_last = 1'b0;
    repeat (5) @(posedge clk_125MHz);
    @(negedge clk_125MHz);
    rst_int = 1'b0;

    idle_chk = 1'b1;
    @(negedge clk_125MHz);
    idle_chk = 1'b0;
    apb_read(REG_STATUS, 32'h0C, 32'h1C, 1'b0);
    finish_test("reset state");

    apb_write(REG_SEND_PORTS, 32'hABCD_1234, 1'b0);
    apb_read(REG_SEND_PORTS, 32'hABCD_1234, 32'hFFFF_FFFF, 1'b0);
    apb_write(REG_SEND_LEN, 32'h155, 1'b0);
    apb_read(REG_SEND_LEN, 32'h155, 32'hFFFF_FFFF, 1'b0);
    apb_read(8'h20, 32'h0, 32'h0, 1'b1);
    apb_write(REG_STATUS, 32'h1F, 1'b1);
    finish_test("register access");

    // Header in wire order where the length counts the 8 header bytes
    hdr = {16'hC0DE, 16'h0035, 16'(SEND_BYTES + 8), 16'h0000};
    for (int i = 0; i < 8; i++) begin
      exp_tx[i] = hdr[(7 - i) * 8 +: 8];
    end
    for (int i = 0; i < SEND_BYTES; i++) begin
      rand_bits(8, b);
      exp_tx[8 + i] = b;
      apb_write(REG_TX_DATA, 32'(b), 1'b0);
    end
    exp_len = SEND_BYTES + 8;
    apb_write(REG_SEND_PORTS, {16'hC0DE, 16'h0035}, 1'b0);
    apb_write(REG_SEND_LEN, 32'(SEND_BYTES), 1'b0);
    apb_write(REG_CTRL, 32'h1, 1'b0);
    waits = 0;
    while (!pkt_sent && waits < 200 * exp_len) begin
      rand_bits(1, b);
      tx_ready = b[0];
      @(negedge clk_125MHz);
      waits++;
    end
    tx_ready = 1'b0;
    if (!pkt_sent) begin
      errors++;
      $display("Packet-sent interrupt never rose");
    end
    check_flags(2'b01);
    apb_write(REG_CTRL, 32'h2, 1'b0);
    check_flags(2'b00);
    finish_test("send with back-pressure");

    hdr = {16'h1F90, 16'h0050, 16'(RX_PAY + 8), 16'hBEEF};
    for (int i = 7; i >= 0; i--) begin
      drive_rx_byte(hdr[i * 8 +: 8], 1'b0);
    end
    for (int i = 0; i < RX_PAY; i++) begin
      rand_bits(8, b);
      rx_exp[i] = b;
      drive_rx_byte(b, i == RX_PAY - 1);
    end
    waits = 0;
    while (!pkt_recv && waits < 200) begin
      @(negedge clk_125MHz);
      waits++;
    end
    check_flags(2'b10);
    apb_read(REG_RECV_PORTS, {16'h1F90, 16'h0050}, 32'hFFFF_FFFF, 1'b0);
    apb_read(REG_RECV_LEN, 32'(RX_PAY + 8), 32'hFFFF_FFFF, 1'b0);
    apb_read(REG_STATUS, 32'(RX_PAY) << 16, 32'h01FF_0000, 1'b0);
    for (int i = 0; i < RX_PAY; i++) begin
      apb_read(REG_RX_DATA, 32'(rx_exp[i]), 32'hFFFF_FFFF, 1'b0);
    end
    apb_read(REG_STATUS, 32'h4, 32'h01FF_0004, 1'b0);
    apb_write(REG_CTRL, 32'h2, 1'b0);
    finish_test("receive frame");

    for (int i = 0; i < SHORT_LEN; i++) begin
      drive_rx_byte(8'(8'h30 + i), i == SHORT_LEN - 1);
    end
    // Done and flag would show within two cycles of the last byte
    repeat (3) @(negedge clk_125MHz);
    check_flags(2'b00);
    apb_read(REG_STATUS, 32'h4, 32'h01FF_0005, 1'b0);
    finish_test("short frame dropped");

    for (int i = 0; i < CLR_BYTES; i++) begin
      apb_write(REG_TX_DATA, 32'(8'hA0 + i), 1'b0);
    end
    apb_read(REG_STATUS, 32'h0, 32'h8, 1'b0);
    apb_write(REG_CTRL, 32'h8, 1'b0);
    apb_read(REG_STATUS, 32'h8, 32'h18, 1'b0);
    finish_test("transmit FIFO clear");

    $display("%0d tests run, %0d failed, %0d check failures", n_tests, n_bad, errors);
    if (errors == 0) begin
      $display("All tests passed");
    end else begin
      $display("Some tests failed");
    end
    $finish;
  end

endmodule

// File: compile.f
eth_udp_pkg.sv
pkt_fifo.sv
udp_tx_framer.sv
udp_rx_parser.sv
eth_csr_apb.sv
udp_endpoint.sv
tb_udp_endpoint.sv

// File: Makefile
# Verilator build and run of the UDP endpoint testbench

VERILATOR ?= verilator
TOP       ?= tb_udp_endpoint
FILELIST  ?= compile.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -Wno-fatal

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	grep -q "All tests passed" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
